//--- filelist.f
logic/rocket_harness_pkg.sv
logic/reset_stretcher.sv
logic/pma_map.sv
logic/tl_responder.sv
logic/muldiv_stub.sv
logic/harness_top.sv
testbench/harness_assertions.sv
testbench/harness_tb.sv

//--- logic/harness_top.sv
`timescale 1ns/1ps

module harness_top (
	input  logic                                            clock,
	input  logic                                            reset,

	input  logic                                            a_valid,
	input  logic [2:0]                                      a_opcode,
	input  logic [2:0]                                      a_param,
	input  logic [rocket_harness_pkg::size_width-1:0]       a_size,
	input  logic [rocket_harness_pkg::source_width-1:0]     a_source,
	input  logic [rocket_harness_pkg::addr_width-1:0]       a_address,
	input  logic [rocket_harness_pkg::xlen_bytes-1:0]       a_mask,
	input  logic [rocket_harness_pkg::xlen-1:0]             a_data,
	output logic                                            a_ready,

	input  logic                                            d_ready,
	output logic                                            d_valid,
	output logic [2:0]                                      d_opcode,
	output logic [1:0]                                      d_param,
	output logic [rocket_harness_pkg::size_width-1:0]       d_size,
	output logic [rocket_harness_pkg::source_width-1:0]     d_source,
	output logic                                            d_sink,
	output logic [rocket_harness_pkg::xlen-1:0]             d_data,
	output logic                                            d_denied,
	output logic                                            d_corrupt,

	input  logic                                            req_valid,
	input  logic [rocket_harness_pkg::muldiv_fn_width-1:0]  req_fn,
	input  logic                                            req_dw,
	input  logic [rocket_harness_pkg::xlen-1:0]             req_in1,
	input  logic [rocket_harness_pkg::xlen-1:0]             req_in2,
	input  logic [rocket_harness_pkg::muldiv_tag_width-1:0] req_tag,
	input  logic                                            kill,
	output logic                                            req_ready,

	input  logic                                            resp_ready,
	output logic                                            resp_valid,
	output logic [rocket_harness_pkg::xlen-1:0]             resp_data,
	output logic [rocket_harness_pkg::muldiv_tag_width-1:0] resp_tag
);

	logic core_reset; // Stretched reset for both peripherals

	reset_stretcher i_reset_stretcher (
		.clock      (clock),
		.reset      (reset),
		.core_reset (core_reset)
	);

	tl_responder i_tl_responder (
		.clock      (clock),
		.core_reset (core_reset),
		.a_valid    (a_valid),
		.a_opcode   (a_opcode),
		.a_param    (a_param),
		.a_size     (a_size),
		.a_source   (a_source),
		.a_address  (a_address),
		.a_mask     (a_mask),
		.a_data     (a_data),
		.a_ready    (a_ready),
		.d_ready    (d_ready),
		.d_valid    (d_valid),
		.d_opcode   (d_opcode),
		.d_param    (d_param),
		.d_size     (d_size),
		.d_source   (d_source),
		.d_sink     (d_sink),
		.d_data     (d_data),
		.d_denied   (d_denied),
		.d_corrupt  (d_corrupt)
	);

	muldiv_stub i_muldiv_stub (
		.clock      (clock),
		.core_reset (core_reset),
		.req_valid  (req_valid),
		.req_fn     (req_fn),
		.req_dw     (req_dw),
		.req_in1    (req_in1),
		.req_in2    (req_in2),
		.req_tag    (req_tag),
		.kill       (kill),
		.req_ready  (req_ready),
		.resp_ready (resp_ready),
		.resp_valid (resp_valid),
		.resp_data  (resp_data),
		.resp_tag   (resp_tag)
	);

endmodule

//--- logic/muldiv_stub.sv
`timescale 1ns/1ps

module muldiv_stub (
	input  logic                                            clock,
	input  logic                                            core_reset,

	input  logic                                            req_valid,
	input  logic [rocket_harness_pkg::muldiv_fn_width-1:0]  req_fn,
	input  logic                                            req_dw,
	input  logic [rocket_harness_pkg::xlen-1:0]             req_in1,
	input  logic [rocket_harness_pkg::xlen-1:0]             req_in2,
	input  logic [rocket_harness_pkg::muldiv_tag_width-1:0] req_tag,
	input  logic                                            kill,
	output logic                                            req_ready,

	input  logic                                            resp_ready,
	output logic                                            resp_valid,
	output logic [rocket_harness_pkg::xlen-1:0]             resp_data,
	output logic [rocket_harness_pkg::muldiv_tag_width-1:0] resp_tag
);
	import rocket_harness_pkg::*;

	logic                        busy;
	logic                        done;
	logic [xlen-1:0]             sum;
	logic [xlen-1:0]             diff;
	muldiv_result_t              raw;
	muldiv_result_t              result;
	logic [xlen-1:0]             held_data;
	logic [muldiv_tag_width-1:0] held_tag;

	always_comb begin
		sum = req_in1 + req_in2;
		diff = req_in1 - req_in2;
		raw.dword = muldiv_fallback;
		case (req_fn)
			4'd0, 4'd1, 4'd3: raw.dword = sum ^ muldiv_key[req_fn[2:0]];
			4'd2, 4'd4, 4'd5, 4'd6, 4'd7: raw.dword = diff ^ muldiv_key[req_fn[2:0]];
			default: begin
			end
		endcase

		result = raw;
		if (!req_dw) begin
			result.word.upper = {32{raw.word.lower[31]}}; // Word form
		end
	end

	assign req_ready = !busy && !core_reset;
	assign resp_valid = done;
	assign resp_data = held_data;
	assign resp_tag = held_tag;

	always_ff @(posedge clock) begin
		if (core_reset || kill) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			if (req_valid && req_ready) begin
				busy <= 1'b1;
			end
			if (busy) begin
				done <= 1'b1; // One cycle of work
			end
			if (resp_valid && resp_ready) begin
				busy <= 1'b0;
				done <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (req_valid && req_ready) begin
			held_data <= result.dword;
			held_tag <= req_tag;
		end
	end

endmodule

//--- logic/pma_map.sv
`timescale 1ns/1ps

module pma_map (
	input  logic [rocket_harness_pkg::xlen-1:0] address,
	input  logic [1:0]                          log2len,
	output logic                                mode_a,
	output logic                                mode_r,
	output logic                                mode_w,
	output logic                                mode_x,
	output logic                                mode_c
);
	import rocket_harness_pkg::*;

	logic [xlen-1:0] address_last;
	logic [4:0]      modes_first;
	logic [4:0]      modes_last;
	logic            misaligned;

	function automatic logic [4:0] region_modes(input logic [xlen-1:0] addr);
		logic [4:0] modes;
		modes = '0; // Unmapped
		for (int i = 0; i < pma_region_count; i++) begin
			if (addr >= pma_base[i] && addr < pma_limit[i]) begin
				modes = pma_modes[i];
			end
		end
		return modes;
	endfunction

	always_comb begin
		address_last = address + (xlen'(1) << log2len) - xlen'(1);
		modes_first = region_modes(address);
		modes_last = region_modes(address_last);

		case (log2len)
			2'd1: misaligned = address[0];
			2'd2: misaligned = |address[1:0];
			2'd3: misaligned = |address[2:0];
			default: misaligned = 1'b0;
		endcase
	end

	// Access must stay inside one region
	always_comb begin
		{mode_a, mode_r, mode_w, mode_x, mode_c} = modes_first & modes_last;
		if (misaligned) begin
			// Execute survives a misaligned access
			{mode_a, mode_r, mode_w, mode_c} = 4'b0000;
		end
	end

endmodule

//--- logic/reset_stretcher.sv
`timescale 1ns/1ps

module reset_stretcher (
	input  logic clock,
	input  logic reset,
	output logic core_reset
);
	import rocket_harness_pkg::*;

	logic [reset_count_width-1:0] count;

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= reset_count_width'(reset_stretch_cycles);
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// Held until the countdown drains
	assign core_reset = reset || (count != '0);

endmodule

//--- logic/rocket_harness_pkg.sv
package rocket_harness_pkg;

	localparam int xlen = 64;
	localparam int xlen_bytes = xlen / 8;
	localparam int addr_width = 32;
	localparam int size_width = 4;
	localparam int source_width = 1;
	localparam int tl_count_width = 16; // Byte offset within a burst

	// TL-UL A channel
	localparam logic [2:0] opcode_a_putfulldata = 3'd0;
	localparam logic [2:0] opcode_a_putpartialdata = 3'd1;
	localparam logic [2:0] opcode_a_get = 3'd4;

	// TL-UL D channel
	localparam logic [2:0] opcode_d_accessack = 3'd0;
	localparam logic [2:0] opcode_d_accessackdata = 3'd1;

	// Address map with exclusive limits and flags A R W X C
	localparam int pma_region_count = 7;
	localparam logic [xlen-1:0] pma_base [pma_region_count] = '{
		64'h0000_0000, 64'h0000_3000, 64'h0001_0000, 64'h0200_0000,
		64'h0c00_0000, 64'h6000_0000, 64'h8000_0000
	};
	localparam logic [xlen-1:0] pma_limit [pma_region_count] = '{
		64'h0000_1000, 64'h0000_4000, 64'h0002_0000, 64'h0201_0000,
		64'h1000_0000, 64'h8000_0000, 64'h8000_4000
	};
	localparam logic [4:0] pma_modes [pma_region_count] = '{
		5'b11110, // debug controller
		5'b11110, // error device
		5'b01010, // rom
		5'b11100, // clint
		5'b11100, // interrupt controller
		5'b01110, // mmio
		5'b11110  // dtim
	};

	localparam int reset_stretch_cycles = 5;
	localparam int reset_count_width = $clog2(reset_stretch_cycles + 1);

	localparam int muldiv_fn_width = 4;
	localparam int muldiv_tag_width = 5;
	localparam logic [xlen-1:0] muldiv_fallback = 64'd123456789;
	localparam logic [xlen-1:0] muldiv_key [8] = '{
		64'h2cdf52a55876063e, // mul
		64'h15d01651f6583fb7, // mulh
		64'hea3969edecfbe137, // mulhsu
		64'hd13db50d949ce5e8, // mulhu
		64'h29bbf66f7f8529ec, // div
		64'h8c629acb10e8fd70, // divu
		64'hf5b7d8538da68fa5, // rem
		64'hbc4402413138d0e1  // remu
	};

	// Doubleword result or two halves for the word form
	typedef union packed {
		logic [xlen-1:0] dword;
		struct packed {
			logic [31:0] upper;
			logic [31:0] lower;
		} word;
	} muldiv_result_t;

endpackage

//--- logic/tl_responder.sv
`timescale 1ns/1ps

module tl_responder (
	input  logic                                        clock,
	input  logic                                        core_reset,

	input  logic                                        a_valid,
	input  logic [2:0]                                  a_opcode,
	input  logic [2:0]                                  a_param,
	input  logic [rocket_harness_pkg::size_width-1:0]   a_size,
	input  logic [rocket_harness_pkg::source_width-1:0] a_source,
	input  logic [rocket_harness_pkg::addr_width-1:0]   a_address,
	input  logic [rocket_harness_pkg::xlen_bytes-1:0]   a_mask,
	input  logic [rocket_harness_pkg::xlen-1:0]         a_data,
	output logic                                        a_ready,

	input  logic                                        d_ready,
	output logic                                        d_valid,
	output logic [2:0]                                  d_opcode,
	output logic [1:0]                                  d_param,
	output logic [rocket_harness_pkg::size_width-1:0]   d_size,
	output logic [rocket_harness_pkg::source_width-1:0] d_source,
	output logic                                        d_sink,
	output logic [rocket_harness_pkg::xlen-1:0]         d_data,
	output logic                                        d_denied,
	output logic                                        d_corrupt
);
	import rocket_harness_pkg::*;

	logic                      busy;
	logic                      last;
	logic [2:0]                op_opcode;
	logic [size_width-1:0]     op_size;
	logic [source_width-1:0]   op_source;
	logic [addr_width-1:0]     op_address;
	logic [tl_count_width-1:0] count;      // Bytes already sent
	logic [tl_count_width-1:0] next_count;
	logic [tl_count_width-1:0] total_bytes;
	logic [1:0]                log2len;
	logic                      mode_r;
	logic                      mode_w;

	// Beat width caps the checked span
	assign log2len = (op_size > size_width'(3)) ? 2'd3 : op_size[1:0];

	pma_map i_pma_map (
		.address (xlen'(op_address)),
		.log2len (log2len),
		.mode_a  (),
		.mode_r  (mode_r),
		.mode_w  (mode_w),
		.mode_x  (),
		.mode_c  ()
	);

	assign d_valid = busy;
	assign a_ready = !core_reset && (!busy || (last && d_valid && d_ready));

	assign total_bytes = tl_count_width'(1) << op_size;
	assign next_count = count + tl_count_width'(xlen_bytes);

	always_comb begin
		d_opcode = opcode_d_accessack;
		d_param = 2'd0;
		d_size = op_size;
		d_source = op_source;
		d_sink = 1'b0;
		d_data = '0;
		d_denied = 1'b1;  // Unsupported by default
		d_corrupt = 1'b1;
		last = 1'b1;

		case (op_opcode)
			opcode_a_get: begin
				d_opcode = opcode_d_accessackdata;
				d_data = xlen'(op_address + addr_width'(count)); // Beat address as data
				d_denied = !mode_r;
				d_corrupt = !mode_r; // Denied data is also corrupt
				last = next_count >= total_bytes;
			end
			opcode_a_putfulldata: begin
				d_denied = !mode_w;
				d_corrupt = 1'b0;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (core_reset) begin
			busy <= 1'b0;
		end else begin
			if (d_valid && d_ready && last) begin
				busy <= 1'b0;
			end
			if (a_valid && a_ready) begin
				busy <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (d_valid && d_ready && !last) begin
			count <= next_count;
		end
		if (a_valid && a_ready) begin
			op_opcode <= a_opcode;
			op_size <= a_size;
			op_source <= a_source;
			op_address <= a_address;
			count <= '0;
		end
	end

endmodule

//--- testbench/harness_assertions.sv
`timescale 1ns/1ps

module harness_assertions (
	input logic                                            clock,
	input logic                                            core_reset,
	input logic                                            a_valid,
	input logic                                            a_ready,
	input logic [2:0]                                      a_opcode,
	input logic [2:0]                                      a_param,
	input logic [rocket_harness_pkg::size_width-1:0]       a_size,
	input logic [rocket_harness_pkg::source_width-1:0]     a_source,
	input logic [rocket_harness_pkg::addr_width-1:0]       a_address,
	input logic [rocket_harness_pkg::xlen_bytes-1:0]       a_mask,
	input logic [rocket_harness_pkg::xlen-1:0]             a_data,
	input logic                                            d_valid,
	input logic                                            d_ready,
	input logic [2:0]                                      d_opcode,
	input logic [rocket_harness_pkg::size_width-1:0]       d_size,
	input logic [rocket_harness_pkg::source_width-1:0]     d_source,
	input logic [rocket_harness_pkg::xlen-1:0]             d_data,
	input logic                                            d_denied,
	input logic                                            d_corrupt,
	input logic                                            kill,
	input logic                                            resp_valid,
	input logic                                            resp_ready,
	input logic [rocket_harness_pkg::xlen-1:0]             resp_data,
	input logic [rocket_harness_pkg::muldiv_tag_width-1:0] resp_tag
);

	a_request_held: assert property (@(posedge clock) disable iff (core_reset)
		a_valid && !a_ready |=> a_valid
			&& $stable({a_opcode, a_param, a_size, a_source, a_address, a_mask, a_data}))
		else $error("A request dropped or changed before acceptance");

	d_beat_held: assert property (@(posedge clock) disable iff (core_reset)
		d_valid && !d_ready |=> d_valid
			&& $stable({d_opcode, d_size, d_source, d_data, d_denied, d_corrupt}))
		else $error("D beat dropped or changed under back-pressure");

	// Kill may withdraw a pending response
	resp_held: assert property (@(posedge clock) disable iff (core_reset)
		resp_valid && !resp_ready && !kill |=> resp_valid && $stable({resp_data, resp_tag}))
		else $error("Multiply/divide response dropped or changed before transfer");

	d_quiet_in_reset: assert property (@(posedge clock) core_reset |-> d_valid !== 1'b1)
		else $error("d_valid high during core reset");

endmodule

bind harness_top harness_assertions i_harness_assertions (.*);

//--- testbench/harness_tb.sv
`timescale 1ns/1ps

module harness_tb;
	import rocket_harness_pkg::*;

	localparam int timeout_cycles = 40;

	logic                        clock = 1'b0;
	logic                        reset = 1'b1;
	logic                        a_valid = 1'b0;
	logic [2:0]                  a_opcode = '0;
	logic [2:0]                  a_param = '0;
	logic [size_width-1:0]       a_size = '0;
	logic [source_width-1:0]     a_source = '0;
	logic [addr_width-1:0]       a_address = '0;
	logic [xlen_bytes-1:0]       a_mask = '1;
	logic [xlen-1:0]             a_data = '0;
	logic                        a_ready;
	logic                        d_ready = 1'b0;
	logic                        d_valid;
	logic [2:0]                  d_opcode;
	logic [1:0]                  d_param;
	logic [size_width-1:0]       d_size;
	logic [source_width-1:0]     d_source;
	logic                        d_sink;
	logic [xlen-1:0]             d_data;
	logic                        d_denied;
	logic                        d_corrupt;
	logic                        req_valid = 1'b0;
	logic [muldiv_fn_width-1:0]  req_fn = '0;
	logic                        req_dw = 1'b0;
	logic [xlen-1:0]             req_in1 = '0;
	logic [xlen-1:0]             req_in2 = '0;
	logic [muldiv_tag_width-1:0] req_tag = '0;
	logic                        kill = 1'b0;
	logic                        req_ready;
	logic                        resp_ready = 1'b0;
	logic                        resp_valid;
	logic [xlen-1:0]             resp_data;
	logic [muldiv_tag_width-1:0] resp_tag;

	int          checks = 0;
	int          errors = 0;
	int          timeouts = 0;
	int          waited;              // Falling edges passed in the last wait
	logic [63:0] rng_state = 64'd43023;

	harness_top i_harness_top (.*);

	always #20 clock = ~clock;

	function automatic logic [63:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 7);
		rng_state = rng_state ^ (rng_state << 17);
		return rng_state;
	endfunction

	task automatic compare_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAIL %0t %s: got %h, expected %h", $time, name, actual, expected);
		end
	endtask

	// Drive point just after the rising edge
	task automatic step();
		@(posedge clock);
		#2;
	endtask

	function automatic logic signal_high(input string name);
		case (name)
			"a_ready": return a_ready;
			"d_valid": return d_valid;
			"req_ready": return req_ready;
			default: return resp_valid;
		endcase
	endfunction

	// Sampled at falling edges away from the drive point
	task automatic wait_high(input string name);
		waited = 0;
		@(negedge clock);
		while (signal_high(name) !== 1'b1 && waited < timeout_cycles) begin
			waited++;
			@(negedge clock);
		end
		if (signal_high(name) !== 1'b1) begin
			timeouts++;
			$display("Timeout at %0t: %s never went high", $time, name);
		end
	endtask

	task automatic send_a(input logic [2:0] opcode, input logic [size_width-1:0] size,
			input logic [addr_width-1:0] address, input logic [source_width-1:0] source);
		a_valid = 1'b1;
		a_opcode = opcode;
		a_size = size;
		a_address = address;
		a_source = source;
		a_data = next_random();
		wait_high("a_ready");
		step();
		a_valid = 1'b0;
	endtask

	task automatic check_d(input logic [2:0] opcode, input logic [size_width-1:0] size,
			input logic [source_width-1:0] source, input logic [xlen-1:0] data,
			input logic denied, input logic corrupt);
		compare_value("d_valid", d_valid, 1'b1);
		compare_value("d_opcode", d_opcode, opcode);
		compare_value("d_param", d_param, 0);
		compare_value("d_size", d_size, size);
		compare_value("d_source", d_source, source);
		compare_value("d_sink", d_sink, 0);
		if (opcode == opcode_d_accessackdata) begin
			compare_value("d_data", d_data, data);
		end
		compare_value("d_denied", d_denied, denied);
		compare_value("d_corrupt", d_corrupt, corrupt);
	endtask

	// One beat taken on the next edge with d_ready high
	task automatic expect_d(input logic [2:0] opcode, input logic [size_width-1:0] size,
			input logic [source_width-1:0] source, input logic [xlen-1:0] data,
			input logic denied, input logic corrupt);
		wait_high("d_valid");
		compare_value("d_valid latency", waited, 0);
		check_d(opcode, size, source, data, denied, corrupt);
		step();
	endtask

	function automatic logic [xlen-1:0] keyed_result(input logic [muldiv_fn_width-1:0] fn,
			input logic dw, input logic [xlen-1:0] in1, input logic [xlen-1:0] in2);
		logic [xlen-1:0] value;
		value = (fn == 0 || fn == 1 || fn == 3) ? in1 + in2 : in1 - in2;
		value = (fn > 7) ? muldiv_fallback : value ^ muldiv_key[fn[2:0]];
		return dw ? value : {{32{value[31]}}, value[31:0]};
	endfunction

	task automatic issue_muldiv(input logic [muldiv_fn_width-1:0] fn, input logic dw,
			output logic [xlen-1:0] expected, output logic [muldiv_tag_width-1:0] tag);
		req_valid = 1'b1;
		req_fn = fn;
		req_dw = dw;
		req_in1 = next_random();
		req_in2 = next_random();
		req_tag = muldiv_tag_width'(next_random());
		expected = keyed_result(fn, dw, req_in1, req_in2);
		tag = req_tag;
		wait_high("req_ready");
		step();
		req_valid = 1'b0;
	endtask

	task automatic run_muldiv(input logic [muldiv_fn_width-1:0] fn, input logic dw);
		logic [xlen-1:0]             expected;
		logic [muldiv_tag_width-1:0] tag;
		resp_ready = 1'b0;
		issue_muldiv(fn, dw, expected, tag);
		compare_value("resp_valid", resp_valid, 1'b0);
		wait_high("resp_valid");
		compare_value("resp_valid latency", waited, 1); // Second edge after accept
		compare_value("resp_data", resp_data, expected);
		compare_value("resp_tag", resp_tag, tag);
		step();
		compare_value("resp_valid", resp_valid, 1'b1);
		compare_value("resp_data", resp_data, expected);
		resp_ready = 1'b1;
		step();
		resp_ready = 1'b0;
		compare_value("resp_valid", resp_valid, 1'b0);
		compare_value("req_ready", req_ready, 1'b1);
	endtask

	task automatic reset_sequence();
		for (int cycle = 0; cycle < 1 + reset_stretch_cycles; cycle++) begin
			@(negedge clock);
			compare_value("a_ready", a_ready, 1'b0);
			compare_value("req_ready", req_ready, 1'b0);
			compare_value("d_valid", d_valid, 1'b0);
			compare_value("resp_valid", resp_valid, 1'b0);
			step();
			if (cycle == 0) begin
				reset = 1'b0; // After two edges
			end
		end
		@(negedge clock);
		compare_value("a_ready", a_ready, 1'b1);
		compare_value("req_ready", req_ready, 1'b1);
		step();
	endtask

	task automatic single_beat_access();
		d_ready = 1'b1;
		send_a(opcode_a_get, 3, 32'h8000_0000, 0);
		expect_d(opcode_d_accessackdata, 3, 0, 64'h8000_0000, 1'b0, 1'b0);
		send_a(opcode_a_putfulldata, 3, 32'h8000_0008, 1);
		expect_d(opcode_d_accessack, 3, 1, 0, 1'b0, 1'b0);
		compare_value("d_valid", d_valid, 1'b0);
	endtask

	task automatic burst_with_backpressure();
		logic [addr_width-1:0] base;
		base = 32'h8000_0100;
		d_ready = 1'b0;
		send_a(opcode_a_get, 5, base, 1);
		for (int beat = 0; beat < 4; beat++) begin
			check_d(opcode_d_accessackdata, 5, 1, base + 8 * beat, 1'b0, 1'b0);
			step();
			check_d(opcode_d_accessackdata, 5, 1, base + 8 * beat, 1'b0, 1'b0);
			d_ready = 1'b1;
			if (beat == 3) begin
				send_a(opcode_a_get, 3, base + 32'h40, 0); // Overlaps the last beat
				compare_value("a_ready wait", waited, 0);
			end else begin
				step();
			end
			d_ready = 1'b0;
		end
		d_ready = 1'b1;
		expect_d(opcode_d_accessackdata, 3, 0, base + 32'h40, 1'b0, 1'b0);
	endtask

	task automatic pma_denial();
		d_ready = 1'b1;
		send_a(opcode_a_putfulldata, 3, 32'h0001_0000, 0);
		expect_d(opcode_d_accessack, 3, 0, 0, 1'b1, 1'b0);
		send_a(opcode_a_get, 3, 32'h0001_0000, 1); // ROM reads are fine
		expect_d(opcode_d_accessackdata, 3, 1, 64'h0001_0000, 1'b0, 1'b0);
		send_a(opcode_a_get, 3, 32'h0000_3004, 1);
		expect_d(opcode_d_accessackdata, 3, 1, 64'h0000_3004, 1'b1, 1'b1);
		send_a(opcode_a_get, 4, 32'h0000_5000, 0);
		expect_d(opcode_d_accessackdata, 4, 0, 64'h0000_5000, 1'b1, 1'b1);
		expect_d(opcode_d_accessackdata, 4, 0, 64'h0000_5008, 1'b1, 1'b1);
		send_a(3'd2, 3, 32'h8000_0000, 1); // TL-UH arithmetic
		expect_d(opcode_d_accessack, 3, 1, 0, 1'b1, 1'b1);
	endtask

	task automatic muldiv_arithmetic();
		for (int fn = 0; fn < 9; fn++) begin
			run_muldiv(muldiv_fn_width'(fn), 1'b1);
			run_muldiv(muldiv_fn_width'(fn), 1'b0);
		end
	endtask

	task automatic muldiv_kill();
		logic [xlen-1:0]             expected;
		logic [muldiv_tag_width-1:0] tag;
		resp_ready = 1'b0;
		issue_muldiv(4'd1, 1'b1, expected, tag);
		kill = 1'b1; // Still busy
		step();
		kill = 1'b0;
		compare_value("resp_valid", resp_valid, 1'b0);
		compare_value("req_ready", req_ready, 1'b1);
		step();
		compare_value("resp_valid", resp_valid, 1'b0);
		issue_muldiv(4'd6, 1'b0, expected, tag);
		wait_high("resp_valid");
		step();
		kill = 1'b1; // Response waiting
		step();
		kill = 1'b0;
		compare_value("resp_valid", resp_valid, 1'b0);
		compare_value("req_ready", req_ready, 1'b1);
		run_muldiv(4'd5, 1'b1);
	endtask

	initial begin
		reset_sequence();
		single_beat_access();
		burst_with_backpressure();
		pma_denial();
		muldiv_arithmetic();
		muldiv_kill();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
